/* all.f */
+incdir+hw
hw/bram_host_pkg.sv
hw/bram_bank_pkg.sv
hw/bram_bank.sv
hw/bram_intrf_translator.sv
hw/bram_req_ctrl.sv
hw/bram_mbank_top.sv
tests/bram_mbank_sva.sv
tests/tb_bram_mbank.sv

/* run_sim.sh */
#!/bin/sh
# build tb_bram_mbank with verilator and run it
# the run passes only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bram_mbank -f all.f -o tb_bram_mbank_sim &&
  ./obj_dir/tb_bram_mbank_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* tests/tb_bram_mbank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bram_mbank_config.svh"

// testbench for the multi-bank memory, host side driver and in-order response checker
module tb_bram_mbank
  import bram_host_pkg::*;
();

  localparam int NUM_ADDR = 1 << `BRAM_IN_ADDR;  // every host word
  localparam int TIMEOUT  = 500;                // cycles allowed per wait

  typedef logic [`BRAM_IN_ADDR-1:0]  haddr_t;
  typedef logic [`BRAM_IN_WIDTH-1:0] word_t;
  typedef logic [`BRAM_IN_WE-1:0]    strb_t;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  bram_req_t req;
  logic      rsp_credit;
  logic      req_credit;
  logic      rsp_valid;
  bram_rsp_t rsp;

  word_t     ref_mem [int];        // reference memory, keyed by host word address
  bram_rsp_t exp_q [$];            // expected responses, oldest first
  string     test_name = "reset";
  int        sent_cnt;             // requests handed to the dut
  int        req_credit_cnt = 0;   // req_credit_o pulses seen
  int        rsp_cnt = 0;          // responses checked
  int        credit_ret_cnt = 0;   // response credits given back
  int        cyc = 0;
  int        last_issue_cyc = 0;
  int        last_rsp_cyc = 0;
  bit        hold_credits;         // consumer withholds response credits

  bram_mbank_top u_bram_mbank_top (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .rsp_credit_i (rsp_credit),
    .req_credit_o (req_credit),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // byte strobes merge new data into the model word
  function automatic void model_write(input haddr_t addr, input word_t data, input strb_t strb);
    if (!ref_mem.exists(int'(addr))) ref_mem[int'(addr)] = '0;
    for (int b = 0; b < `BRAM_IN_WE; b++) begin
      if (strb[b]) ref_mem[int'(addr)][b*8 +: 8] = data[b*8 +: 8];
    end
  endfunction

  // a read returns whatever the model holds after all older writes
  function automatic word_t expected_word(input haddr_t addr);
    return ref_mem[int'(addr)];
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // one request beat, only while a request credit is held
  task automatic send_req(input bram_op_e op, input haddr_t addr, input word_t data,
                          input strb_t strb);
    bram_rsp_t exp;
    int        waited;
    waited = 0;
    while ((sent_cnt - req_credit_cnt) >= `BRAM_REQ_DEPTH) begin
      if (waited == TIMEOUT) abort_run("timed out waiting for a request credit");
      idle_cycles(1);
      waited++;
    end
    req_valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = data;
    req.wstrb = strb;
    sent_cnt++;
    if (op == OP_WRITE) begin
      model_write(addr, data, strb);
    end else begin
      exp.addr  = addr;
      exp.rdata = expected_word(addr);
      exp_q.push_back(exp);
    end
    idle_cycles(1);
    req_valid = 1'b0;
    req       = '0;
  endtask

  // all requests issued, all responses checked, all credits back
  task automatic wait_quiet();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || sent_cnt != req_credit_cnt || rsp_cnt != credit_ret_cnt) begin
      if (waited == TIMEOUT) abort_run("timed out waiting for outstanding requests to drain");
      idle_cycles(1);
      waited++;
    end
  endtask

  // stimulus
  initial begin
    int order [NUM_ADDR];
    int tmp;
    int j;
    int base;
    void'($urandom(41880));
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    sent_cnt     = 0;
    hold_credits = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idle_cycles(2);

    test_name = "full_write_read";
    for (int i = 0; i < 8; i++) send_req(OP_WRITE, haddr_t'(i * 37), $urandom(), '1);
    for (int i = 0; i < 8; i++) send_req(OP_READ, haddr_t'(i * 37), '0, '0);
    wait_quiet();

    test_name = "partial_strobe";  // strobes 1..14, never all or none
    for (int i = 0; i < 8; i++) begin
      send_req(OP_WRITE, haddr_t'(i * 37), $urandom(), strb_t'($urandom_range(14, 1)));
    end
    for (int i = 0; i < 8; i++) send_req(OP_READ, haddr_t'(i * 37), '0, '0);
    wait_quiet();

    test_name = "all_addr_random";
    for (int i = 0; i < NUM_ADDR; i++) begin
      send_req(OP_WRITE, haddr_t'(i), ($urandom() & 32'h007f_ffff) | (i << 23), '1);  // addr on top
      order[i] = i;
    end
    for (int i = NUM_ADDR - 1; i > 0; i--) begin
      j        = $urandom_range(i, 0);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < NUM_ADDR; i++) send_req(OP_READ, haddr_t'(order[i]), '0, '0);
    wait_quiet();

    test_name = "req_credits";  // burst spends every request credit
    for (int i = 0; i < `BRAM_REQ_DEPTH; i++) send_req(OP_WRITE, haddr_t'(i + 300), $urandom(), '1);
    idle_cycles(10);
    check_value(test_name, sent_cnt, req_credit_cnt);

    test_name = "rsp_backpressure";
    wait_quiet();
    base         = rsp_cnt;
    hold_credits = 1'b1;
    for (int i = 0; i < 6; i++) send_req(OP_READ, haddr_t'(i * 5), '0, '0);
    idle_cycles(20);
    check_value({test_name, "_held"}, `BRAM_RSP_CREDITS, rsp_cnt - base);
    hold_credits = 1'b0;
    wait_quiet();

    test_name = "read_latency";
    idle_cycles(5);
    send_req(OP_READ, haddr_t'(9'h1a5), '0, '0);
    wait_quiet();
    check_value(test_name, 2, last_rsp_cyc - last_issue_cyc);

    $display("Test OK");
    $finish;
  end

  // issue and timing monitor, mid cycle where outputs are settled
  always @(negedge clk) begin
    cyc++;
    if (rst_n && req_credit) begin
      req_credit_cnt++;
      last_issue_cyc = cyc;  // issue cycle of the latest request
    end
    if (rst_n && rsp_valid) last_rsp_cyc = cyc;
  end

  // response checker, strictly in request order
  always @(negedge clk) begin : compare
    bram_rsp_t exp;
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("a response arrived with no read outstanding");
      end else begin
        exp = exp_q.pop_front();
        check_value({test_name, "_rdata"}, exp.rdata, rsp.rdata);
        check_value({test_name, "_addr"}, exp.addr, rsp.addr);
        rsp_cnt++;
      end
    end
  end

  // consumer gives one credit back per checked response unless held
  initial begin
    bit give;
    rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      give = !hold_credits && (rsp_cnt > credit_ret_cnt);  // decided off the drive edge
      #1;
      rsp_credit = give;
      if (give) credit_ret_cnt++;
    end
  end

  initial begin
    #2_000_000;
    abort_run("simulation watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

/* tests/bram_mbank_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bram_mbank_config.svh"

// credit and bank enable checks on the memory subsystem
module bram_mbank_sva
  import bram_host_pkg::*;
  import bram_bank_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       req_credit_i,
  input logic       rsp_valid_i,
  input logic       rsp_credit_i,
  input bram_port_t port_i,
  input bank_port_t bank_i [`BRAM_BANKS]
);

  logic [3:0]             held_q;   // credits the consumer granted and not yet used
  logic [`BRAM_BANKS-1:0] bank_en;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q <= 4'(`BRAM_RSP_CREDITS);
    end else begin
      held_q <= held_q + 4'(rsp_credit_i) - 4'(rsp_valid_i);  // grant in, response out
    end
  end

  always_comb begin
    for (int b = 0; b < `BRAM_BANKS; b++) bank_en[b] = bank_i[b].en;
  end

  a_rsp_covered: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> held_q != '0)
    else $error("response sent with no response credit outstanding");

  // every item of a word lands in a distinct bank
  a_bank_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    port_i.en |-> $countones(bank_en) == `BRAM_WORD_DATA)
    else $error("port access enabled the wrong number of banks");

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !req_credit_i && !rsp_valid_i)
    else $error("credit or response active during reset");

endmodule

bind bram_mbank_top bram_mbank_sva u_bram_mbank_sva (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_credit_i (req_credit_o),
  .rsp_valid_i  (rsp_valid_o),
  .rsp_credit_i (rsp_credit_i),
  .port_i       (mem_port),
  .bank_i       (bank_port)
);

`default_nettype wire

/* hw/bram_mbank_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bram_mbank_config.svh"

// multi-bank memory subsystem with credit based request and response channels
module bram_mbank_top
  import bram_host_pkg::*;
  import bram_bank_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  bram_req_t req_i,
  input  logic      rsp_credit_i,
  output logic      req_credit_o,
  output logic      rsp_valid_o,
  output bram_rsp_t rsp_o
);

  bram_port_t                mem_port;                  // controller to translator
  logic [`BRAM_IN_WIDTH-1:0] mem_rdata;                 // steered read word
  bank_port_t                bank_port  [`BRAM_BANKS];
  bank_word_t                bank_rdata [`BRAM_BANKS];

  // request queue and response tracking
  bram_req_ctrl u_req_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .rsp_credit_i (rsp_credit_i),
    .port_rdata_i (mem_rdata),
    .req_credit_o (req_credit_o),
    .port_o       (mem_port),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  // wide port to bank ports
  bram_intrf_translator u_translator (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .port_i       (mem_port),
    .bank_rdata_i (bank_rdata),
    .bank_o       (bank_port),
    .port_rdata_o (mem_rdata)
  );

  // bank array, one instance per bank port
  for (genvar b = 0; b < `BRAM_BANKS; b++) begin : g_bank
    bram_bank u_bank (
      .clk_i   (clk_i),
      .bank_i  (bank_port[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

`default_nettype wire

/* hw/bram_req_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bram_mbank_config.svh"

// queues host requests, issues one per cycle to the memory port,
// tracks reads in flight and returns responses in order
module bram_req_ctrl
  import bram_host_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  input  bram_req_t                 req_i,
  input  logic                      rsp_credit_i,
  input  logic [`BRAM_IN_WIDTH-1:0] port_rdata_i,
  output logic                      req_credit_o,
  output bram_port_t                port_o,
  output logic                      rsp_valid_o,
  output bram_rsp_t                 rsp_o
);

  localparam int DEPTH = `BRAM_REQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`BRAM_RSP_CREDITS + 1);

  bram_req_t                fifo_q [DEPTH];  // request storage
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic [CRD_W-1:0]         rsp_crd_q;       // credits held minus reads in flight
  bram_req_t                head;
  logic                     push;
  logic                     head_valid;
  logic                     head_rd;
  logic                     issue;
  logic                     issue_rd;
  logic                     s1_valid_q;      // read issued last cycle
  logic [`BRAM_IN_ADDR-1:0] s1_addr_q;

  // sender holds a credit per free slot, full check is only a guard
  assign push       = req_valid_i && (count_q != CNT_W'(DEPTH));
  assign head       = fifo_q[rd_ptr_q];
  assign head_valid = (count_q != '0);
  assign head_rd    = (head.op == OP_READ);

  // writes go whenever queued, reads need a free response slot
  assign issue    = head_valid && (!head_rd || (rsp_crd_q != '0));
  assign issue_rd = issue && head_rd;

  assign req_credit_o = issue;  // a slot frees on issue

  // drive the wide port straight from the head entry
  always_comb begin
    port_o        = '0;
    port_o.en     = issue;
    port_o.addr   = head.addr;
    port_o.wrdata = head.wdata;
    if (!head_rd) begin
      port_o.we = head.wstrb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= req_i;
    end
  end

  // queue pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two, wraps
      if (issue) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, issue})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // response credits, spent on read issue and given back by the consumer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_crd_q <= CRD_W'(`BRAM_RSP_CREDITS);
    end else begin
      case ({issue_rd, rsp_credit_i})
        2'b10:   rsp_crd_q <= rsp_crd_q - 1'b1;
        2'b01:   rsp_crd_q <= rsp_crd_q + 1'b1;
        default: rsp_crd_q <= rsp_crd_q;
      endcase
    end
  end

  // read pipeline: issue, bank data, response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= issue_rd;
      rsp_valid_o <= s1_valid_q;  // two cycles after issue
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_rd) begin
      s1_addr_q <= head.addr;
    end
    if (s1_valid_q) begin
      rsp_o.addr  <= s1_addr_q;
      rsp_o.rdata <= port_rdata_i;  // word steered back by the translator
    end
  end

endmodule

`default_nettype wire

/* hw/bram_intrf_translator.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bram_mbank_config.svh"

// splits the wide memory port into per-bank ports and rebuilds the read word
module bram_intrf_translator
  import bram_host_pkg::*;
  import bram_bank_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  bram_port_t                port_i,
  input  bank_word_t                bank_rdata_i [`BRAM_BANKS],
  output bank_port_t                bank_o [`BRAM_BANKS],
  output logic [`BRAM_IN_WIDTH-1:0] port_rdata_o
);

  localparam int WORD_DATA = `BRAM_WORD_DATA;
  localparam int BANKS     = `BRAM_BANKS;
  localparam int BANK_BITS = `BRAM_BANK_BITS;
  localparam int INJ       = `BRAM_INJ_BITS;
  localparam int OUT_ADDR  = `BRAM_OUT_ADDR;
  localparam int OUT_WIDTH = `BRAM_OUT_WIDTH;
  localparam int OUT_WE    = `BRAM_OUT_WE;
  localparam int ITRL_ADDR = `BRAM_IN_ADDR + `BRAM_INJ_BITS;  // item level address

  logic [ITRL_ADDR-1:0]                itrl_addr [WORD_DATA];  // {host addr, item index}
  logic [WORD_DATA-1:0][BANK_BITS-1:0] target;                 // bank hit by each item
  logic [BANKS-1:0]                    en_reduct;              // banks hit by any item
  logic [BANKS-1:0]                    bank_en;
  bank_rret_t                          ret_q;                  // steering for returning data

  function automatic logic [BANKS-1:0] bin_to_onehot(input logic [BANK_BITS-1:0] bin);
    bin_to_onehot      = '0;
    bin_to_onehot[bin] = 1'b1;
  endfunction

  // item addresses: consecutive items land in consecutive banks
  always_comb begin
    en_reduct = '0;
    for (int j = 0; j < WORD_DATA; j++) begin
      itrl_addr[j] = {port_i.addr, INJ'(j)};
      target[j]    = itrl_addr[j][BANK_BITS-1:0];       // low bits pick the bank
      en_reduct    = en_reduct | bin_to_onehot(target[j]);
    end
  end

  assign bank_en = port_i.en ? en_reduct : '0;

  // route each item's data, strobes and bank address to its bank
  always_comb begin
    for (int b = 0; b < BANKS; b++) begin
      bank_o[b]    = '0;
      bank_o[b].en = bank_en[b];
      for (int j = 0; j < WORD_DATA; j++) begin
        if (target[j] == BANK_BITS'(b)) begin
          bank_o[b].we     = port_i.we[j*OUT_WE +: OUT_WE];
          bank_o[b].addr   = itrl_addr[j][BANK_BITS +: OUT_ADDR];
          bank_o[b].wrdata = port_i.wrdata[j*OUT_WIDTH +: OUT_WIDTH];
        end
      end
    end
  end

  // banks answer one cycle late, so keep the item-to-bank map of the read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ret_q <= '0;
    end else begin
      ret_q.valid <= port_i.en & ~|port_i.we;
      if (port_i.en && port_i.we == '0) begin
        ret_q.bank_sel <= target;                        // only a read moves the map
      end
    end
  end

  // rebuild the word, item 0 in the lsbs
  always_comb begin
    for (int j = 0; j < WORD_DATA; j++) begin
      port_rdata_o[j*OUT_WIDTH +: OUT_WIDTH] =
        ret_q.valid ? bank_rdata_i[ret_q.bank_sel[j]] : '0;
    end
  end

endmodule

`default_nettype wire

/* hw/bram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bram_mbank_config.svh"

// one single-port bank, byte writable, read-first with registered output
module bram_bank
  import bram_bank_pkg::*;
(
  input  logic       clk_i,
  input  bank_port_t bank_i,
  output bank_word_t rdata_o
);

  localparam int DEPTH  = `BRAM_OUT_DEPTH;
  localparam int OUT_WE = `BRAM_OUT_WE;

  bank_word_t mem [DEPTH];  // contents undefined until written

  // read data is the old contents on a write to the same entry
  always_ff @(posedge clk_i) begin
    if (bank_i.en) begin
      rdata_o <= mem[bank_i.addr];
    end
  end

  // per-byte write, each lane independent
  always_ff @(posedge clk_i) begin
    if (bank_i.en) begin
      for (int b = 0; b < OUT_WE; b++) begin
        if (bank_i.we[b]) begin
          mem[bank_i.addr][b*8 +: 8] <= bank_i.wrdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/bram_bank_pkg.sv */
`default_nettype none

// bank side view: narrow bank ports and read steering info
package bram_bank_pkg;

  `include "bram_mbank_config.svh"

  // one bank data item
  typedef logic [`BRAM_OUT_WIDTH-1:0] bank_word_t;

  // port of one narrow bank
  typedef struct packed {
    logic                       en;
    logic [`BRAM_OUT_WE-1:0]    we;      // byte enables of the routed item
    logic [`BRAM_OUT_ADDR-1:0]  addr;
    logic [`BRAM_OUT_WIDTH-1:0] wrdata;
  } bank_port_t;

  // captured on a read, used one cycle later to steer bank data back
  typedef struct packed {
    logic                                            valid;     // read data due this cycle
    logic [`BRAM_WORD_DATA-1:0][`BRAM_BANK_BITS-1:0] bank_sel;  // source bank per item
  } bank_rret_t;

endpackage

`default_nettype wire

/* hw/bram_host_pkg.sv */
`default_nettype none

// host side view: request and response channels and the wide memory port
package bram_host_pkg;

  `include "bram_mbank_config.svh"

  // request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bram_op_e;

  // one request beat, 46 bits
  typedef struct packed {
    bram_op_e                  op;
    logic [`BRAM_IN_ADDR-1:0]  addr;   // host word address
    logic [`BRAM_IN_WIDTH-1:0] wdata;
    logic [`BRAM_IN_WE-1:0]    wstrb;  // byte strobes, ignored for reads
  } bram_req_t;

  // one read response word, 41 bits
  typedef struct packed {
    logic [`BRAM_IN_ADDR-1:0]  addr;
    logic [`BRAM_IN_WIDTH-1:0] rdata;
  } bram_rsp_t;

  // single wide port as a bram controller would drive it
  typedef struct packed {
    logic                      en;
    logic [`BRAM_IN_WE-1:0]    we;      // all zero means read
    logic [`BRAM_IN_ADDR-1:0]  addr;
    logic [`BRAM_IN_WIDTH-1:0] wrdata;
  } bram_port_t;

endpackage

`default_nettype wire

/* hw/bram_mbank_config.svh */
`ifndef BRAM_MBANK_CONFIG_SVH
`define BRAM_MBANK_CONFIG_SVH

// base sizes of the memory subsystem
`define BRAM_IN_WIDTH   32   // host word width
`define BRAM_OUT_WIDTH  16   // bank word width, one data item
`define BRAM_BANKS      4    // must be a power of two
`define BRAM_OUT_DEPTH  256  // entries per bank

// items packed in a host word, lsb item first
`define BRAM_WORD_DATA  (`BRAM_IN_WIDTH / `BRAM_OUT_WIDTH)

// one strobe bit per byte
`define BRAM_IN_WE      (`BRAM_IN_WIDTH / 8)
`define BRAM_OUT_WE     (`BRAM_OUT_WIDTH / 8)

// address widths
`define BRAM_OUT_ADDR   $clog2(`BRAM_OUT_DEPTH)
`define BRAM_BANK_BITS  $clog2(`BRAM_BANKS)
`define BRAM_INJ_BITS   $clog2(`BRAM_WORD_DATA)  // item index appended below host addr
`define BRAM_IN_ADDR    ($clog2(`BRAM_BANKS * `BRAM_OUT_DEPTH) - `BRAM_INJ_BITS)

// flow control
`define BRAM_REQ_DEPTH   4  // request fifo entries = sender credits after reset
`define BRAM_RSP_CREDITS 2  // response credits held by the controller after reset

`endif
